// ==== common/fifo_pkg.sv ====
package fifo_pkg;

    // Word and address widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 4;

    // Storage depth follows from the address width
    localparam int DEPTH = 1 << ADDR_W;

    // One extra pointer bit separates full from empty
    localparam int PTR_W = ADDR_W + 1;

    // A stored data word
    typedef logic [DATA_W-1:0] data_t;

    // Index into the storage array
    typedef logic [ADDR_W-1:0] addr_t;

    // Binary or Gray pointer, including the wrap bit
    typedef logic [PTR_W-1:0] ptr_t;

    // Binary to Gray conversion, shared by both pointer blocks
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage

// ==== common/fifo_mem_if.sv ====
interface fifo_mem_if;

    import fifo_pkg::*;

    // Write port, wr_clk domain
    logic  wr_en_mem;
    addr_t wr_addr;
    data_t wr_data;  // Driven by the top level

    // Read port, rd_clk domain
    logic  rd_en_mem;
    addr_t rd_addr;
    data_t rd_data;  // Registered RAM output

    // Write pointer block
    modport writer (
        output wr_en_mem,
        output wr_addr
    );

    // Read pointer block
    modport reader (
        output rd_en_mem,
        output rd_addr
    );

    // Storage array
    modport ram (
        input  wr_en_mem,
        input  wr_addr,
        input  wr_data,
        input  rd_en_mem,
        input  rd_addr,
        output rd_data
    );

endinterface

// ==== async_fifo/gray_sync.sv ====
module gray_sync #(
    parameter int SYNC_STAGES = 2  // Chain length, 2 or more
) (
    input  logic           clk,       // Destination clock
    input  logic           rst_n,     // Destination reset
    input  fifo_pkg::ptr_t gray_in,   // Pointer from the other domain
    output fifo_pkg::ptr_t gray_out
);

    import fifo_pkg::*;

    // Flop chain, first stage may go metastable
    ptr_t stage [SYNC_STAGES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= gray_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                stage[i] <= stage[i-1];  // Shift toward the output
            end
        end
    end

    // Gray coding keeps the sampled value within one step of the source
    assign gray_out = stage[SYNC_STAGES-1];

endmodule

// ==== async_fifo/fifo_mem.sv ====
module fifo_mem (
    input logic       wr_clk,
    input logic       rd_clk,
    input logic       rd_rst_n,
    fifo_mem_if.ram   mem
);

    import fifo_pkg::*;

    // Storage array, contents are undefined until written
    data_t ram [DEPTH];

    // Write port
    always_ff @(posedge wr_clk) begin
        if (mem.wr_en_mem) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered read port, holds its value between reads
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            mem.rd_data <= '0;
        end else if (mem.rd_en_mem) begin
            mem.rd_data <= ram[mem.rd_addr];  // Valid the cycle after the read
        end
    end

endmodule

// ==== async_fifo/wr_ptr_full.sv ====
module wr_ptr_full (
    input  logic           wr_clk,
    input  logic           wr_rst_n,
    input  logic           wr_en,
    input  fifo_pkg::ptr_t rd_gray_sync,  // Read pointer after the synchronizer
    output fifo_pkg::ptr_t wr_gray,
    output logic           full,
    fifo_mem_if.writer     mem
);

    import fifo_pkg::*;

    ptr_t wr_bin;        // Binary write pointer
    ptr_t wr_bin_next;
    ptr_t wr_gray_next;
    ptr_t full_match;    // Gray value the write pointer has when full
    logic wr_accept;

    // Writes are dropped while full
    assign wr_accept = wr_en && !full;

    assign wr_bin_next  = wr_bin + ptr_t'(wr_accept);
    assign wr_gray_next = bin2gray(wr_bin_next);

    // Full means one lap ahead, so the two top Gray bits differ
    assign full_match = {~rd_gray_sync[PTR_W-1:PTR_W-2], rd_gray_sync[PTR_W-3:0]};

    // Memory write port
    assign mem.wr_en_mem = wr_accept;
    assign mem.wr_addr   = wr_bin[ADDR_W-1:0];

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;  // Only one bit moves per write
        end
    end

    // Registered full flag, may lag a read by the sync delay
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            full <= 1'b0;
        end else begin
            full <= (wr_gray_next == full_match);
        end
    end

endmodule

// ==== async_fifo/rd_ptr_empty.sv ====
module rd_ptr_empty (
    input  logic           rd_clk,
    input  logic           rd_rst_n,
    input  logic           rd_en,
    input  fifo_pkg::ptr_t wr_gray_sync,  // Write pointer after the synchronizer
    output fifo_pkg::ptr_t rd_gray,
    output logic           empty,
    fifo_mem_if.reader     mem
);

    import fifo_pkg::*;

    ptr_t rd_bin;        // Binary read pointer
    ptr_t rd_bin_next;
    ptr_t rd_gray_next;
    logic rd_accept;

    // Reads are dropped while empty
    assign rd_accept = rd_en && !empty;

    assign rd_bin_next  = rd_bin + ptr_t'(rd_accept);
    assign rd_gray_next = bin2gray(rd_bin_next);

    // Memory read port, the RAM registers the word on this edge
    assign mem.rd_en_mem = rd_accept;
    assign mem.rd_addr   = rd_bin[ADDR_W-1:0];

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_gray_next;
        end
    end

    // Empty when both pointers match, including the wrap bit
    // A late write pointer only keeps empty set longer
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            empty <= 1'b1;
        end else begin
            empty <= (rd_gray_next == wr_gray_sync);
        end
    end

endmodule

// ==== async_fifo/async_fifo.sv ====
module async_fifo #(
    parameter int SYNC_STAGES = 2  // Flops per pointer synchronizer
) (
    // Write clock domain
    input  logic            wr_clk,
    input  logic            wr_rst_n,
    input  logic            wr_en,
    input  fifo_pkg::data_t wr_data,
    output logic            full,

    // Read clock domain
    input  logic            rd_clk,
    input  logic            rd_rst_n,
    input  logic            rd_en,
    output fifo_pkg::data_t rd_data,
    output logic            empty
);

    import fifo_pkg::*;

    ptr_t wr_gray;       // Write pointer, wr_clk domain
    ptr_t rd_gray;       // Read pointer, rd_clk domain
    ptr_t wr_gray_sync;  // Write pointer seen in rd_clk domain
    ptr_t rd_gray_sync;  // Read pointer seen in wr_clk domain

    fifo_mem_if mem_if ();

    // Data path goes straight through the memory bundle
    assign mem_if.wr_data = wr_data;
    assign rd_data        = mem_if.rd_data;

    wr_ptr_full u_wr_ptr_full (
        .wr_clk       (wr_clk),
        .wr_rst_n     (wr_rst_n),
        .wr_en        (wr_en),
        .rd_gray_sync (rd_gray_sync),
        .wr_gray      (wr_gray),
        .full         (full),
        .mem          (mem_if.writer)
    );

    rd_ptr_empty u_rd_ptr_empty (
        .rd_clk       (rd_clk),
        .rd_rst_n     (rd_rst_n),
        .rd_en        (rd_en),
        .wr_gray_sync (wr_gray_sync),
        .rd_gray      (rd_gray),
        .empty        (empty),
        .mem          (mem_if.reader)
    );

    fifo_mem u_fifo_mem (
        .wr_clk   (wr_clk),
        .rd_clk   (rd_clk),
        .rd_rst_n (rd_rst_n),
        .mem      (mem_if.ram)
    );

    // Write pointer into the read domain
    gray_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync_w2r (
        .clk      (rd_clk),
        .rst_n    (rd_rst_n),
        .gray_in  (wr_gray),
        .gray_out (wr_gray_sync)
    );

    // Read pointer into the write domain
    gray_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync_r2w (
        .clk      (wr_clk),
        .rst_n    (wr_rst_n),
        .gray_in  (rd_gray),
        .gray_out (rd_gray_sync)
    );

endmodule

// ==== bench/tb_async_fifo.sv ====
module tb_async_fifo;

    timeunit 1ns;
    timeprecision 100ps;

    import fifo_pkg::*;

    localparam int SYNC_STAGES = 2;

    logic  wr_clk = 1'b0;
    logic  rd_clk = 1'b0;
    logic  wr_rst_n;
    logic  rd_rst_n;
    logic  wr_en = 1'b0;
    data_t wr_data = '0;
    logic  rd_en = 1'b0;
    logic  full;
    logic  empty;
    data_t rd_data;

    integer seed = 20;
    int     wr_prob = 0;      // Chance of wr_en per wr_clk cycle in percent
    int     rd_prob = 0;      // Chance of rd_en per rd_clk cycle in percent
    bit     monitor_on = 1'b0;
    bit     wr_hold = 1'b0;   // Last offered word was refused

    // Reference model of the FIFO contents
    data_t  model [$];
    int     wr_count = 0;     // Accepted writes so far
    int     rd_count = 0;     // Accepted reads so far
    bit     rd_pending = 1'b0;
    data_t  rd_expected = '0;
    data_t  last_rd_data = '0;

    async_fifo #(
        .SYNC_STAGES (SYNC_STAGES)
    ) DUT (
        .wr_clk   (wr_clk),
        .wr_rst_n (wr_rst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .full     (full),
        .rd_clk   (rd_clk),
        .rd_rst_n (rd_rst_n),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .empty    (empty)
    );

    always #50 rd_clk = ~rd_clk;  // 100 ns
    always #35 wr_clk = ~wr_clk;  // 70 ns and unrelated to rd_clk

    function automatic int roll_percent();
        int unsigned r;
        r = $random(seed);
        return int'(r % 100);
    endfunction

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%0t ns: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %02h, expected %02h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    // Polls full on falling wr_clk edges where it is stable
    task automatic wait_full(input logic value, input int limit);
        int n;
        n = 0;
        @(negedge wr_clk);
        while (full !== value) begin
            if (n >= limit) begin
                report_failure($sformatf("timeout waiting for full to become %b", value));
            end
            n++;
            @(negedge wr_clk);
        end
    endtask

    task automatic wait_empty(input logic value, input int limit);
        int n;
        n = 0;
        @(negedge rd_clk);
        while (empty !== value) begin
            if (n >= limit) begin
                report_failure($sformatf("timeout waiting for empty to become %b", value));
            end
            n++;
            @(negedge rd_clk);
        end
    endtask

    // Lets exactly one read through and then stops reading
    task automatic read_one(input int limit);
        int start;
        int n;
        start = rd_count;
        n = 0;
        rd_prob = 100;
        @(posedge rd_clk);
        while (rd_count == start) begin
            if (n >= limit) begin
                report_failure("timeout waiting for a single read to be accepted");
            end
            n++;
            @(posedge rd_clk);
        end
        rd_prob = 0;
    endtask

    task automatic run_phase(input int wr_p, input int rd_p, input int cycles);
        wr_prob = wr_p;
        rd_prob = rd_p;
        repeat (cycles) @(posedge rd_clk);
    endtask

    always @(posedge wr_clk) begin
        #5;
        wr_en <= (roll_percent() < wr_prob);
        if (!wr_hold) begin
            wr_data <= data_t'($random(seed));  // A refused word is offered again
        end
    end

    always @(posedge rd_clk) begin
        #5;
        rd_en <= (roll_percent() < rd_prob);
    end

    // Push side of the model sampled mid cycle
    always @(negedge wr_clk) begin
        wr_hold = wr_en && full;
        if (monitor_on && wr_en && !full) begin
            model.push_back(wr_data);
            wr_count++;
            if (model.size() > DEPTH) begin
                report_failure($sformatf("model holds %0d words after a write, limit is %0d",
                                         model.size(), DEPTH));
            end
        end
    end

    // Pop side of the model and read data check
    always @(negedge rd_clk) begin
        if (monitor_on) begin
            if (rd_pending) begin
                check_data("rd_data", rd_data, rd_expected);
                last_rd_data = rd_expected;
                rd_pending   = 1'b0;
            end else begin
                check_data("rd_data", rd_data, last_rd_data);  // Holds between reads
            end
            if (rd_en && !empty) begin
                if (model.size() == 0) begin
                    report_failure("read accepted while the model holds no word");
                end else begin
                    rd_expected = model.pop_front();
                    rd_pending  = 1'b1;
                    rd_count++;
                end
            end
        end
    end

    initial begin
        int fill_start;

        wr_rst_n = 1'b0;
        rd_rst_n = 1'b0;
        repeat (10) @(posedge rd_clk);
        #5;
        rd_rst_n   = 1'b1;
        monitor_on = 1'b1;
        @(posedge wr_clk);
        #5;
        wr_rst_n = 1'b1;

        @(negedge rd_clk);
        check_flag("empty", empty, 1'b1);
        check_flag("full", full, 1'b0);
        check_data("rd_data", rd_data, '0);

        // Fill without reads until full
        fill_start = wr_count;
        wr_prob = 100;
        rd_prob = 0;
        wait_full(1'b1, 60);
        if (wr_count - fill_start != DEPTH) begin
            report_failure($sformatf("full rose after %0d accepted writes, expected %0d",
                                     wr_count - fill_start, DEPTH));
        end
        repeat (8) @(posedge wr_clk);  // Words offered here must be dropped
        wr_prob = 0;

        // One read from a full FIFO releases full
        read_one(10);
        wait_full(1'b0, 20);

        // Drain, then keep reading while empty
        rd_prob = 100;
        wait_empty(1'b1, 60);
        if (model.size() != 0) begin
            report_failure($sformatf("empty rose with %0d words left in the model",
                                     model.size()));
        end
        repeat (8) @(posedge rd_clk);
        rd_prob = 0;

        run_phase(85, 25, 300);   // Filling
        run_phase(25, 85, 300);   // Draining
        run_phase(50, 50, 400);   // Balanced
        run_phase(95, 5, 150);
        run_phase(5, 95, 150);

        // Stop writes and let the write pointer reach the read side
        wr_prob = 0;
        rd_prob = 100;
        repeat (2) @(posedge wr_clk);
        repeat (SYNC_STAGES + 2) @(posedge rd_clk);
        wait_empty(1'b1, 100);
        if (model.size() != 0) begin
            report_failure($sformatf("empty rose with %0d words left in the model",
                                     model.size()));
        end
        wait_full(1'b0, 20);
        rd_prob = 0;
        repeat (4) @(posedge rd_clk);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
common/fifo_pkg.sv
common/fifo_mem_if.sv
async_fifo/gray_sync.sv
async_fifo/fifo_mem.sv
async_fifo/wr_ptr_full.sv
async_fifo/rd_ptr_empty.sv
async_fifo/async_fifo.sv
bench/tb_async_fifo.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_async_fifo
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the simulator
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without errors"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
